/* hw/pi1q.sv */
////////////////////////////////////////
// pi1q queued interconnect
// masters take turns in a round-robin slot
// queue feeding one slave, read data is
// returned per master on its next ready
////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module pi1q (
	input  wire logic                      m_clk_i,
	input  wire logic                      rst_i,
	input  wire pi_pkg::pi_req_t           m_req_i [pi_pkg::MASTERCOUNT],
	output logic [pi_pkg::MASTERCOUNT-1:0] m_rdy_o,
	output pi_pkg::pi_data_t               m_data_o [pi_pkg::MASTERCOUNT],
	output pi_pkg::pi_req_t                s_req_o,
	input  wire logic                      s_rdy_i,
	input  wire pi_pkg::pi_data_t          s_data_i
);
	import pi_pkg::*;

	// indexes carry a wrap bit above the slot number
	logic [MASTERIDXSZ:0] wr_idx, rd_idx, wr_next, rd_next, usage;
	logic [MASTERIDXSZ-1:0] wr_lo, rd_lo, prev_rd;
	// last slot of the rotation on the write side and on the read side
	logic [MASTERIDXSZ-1:0] mstrhi, slvhi;
	// scanner state and the rotation limit it proposes
	logic [MASTERIDXSZ-1:0] scan_idx, mstrhinxt;
	logic scan_hit;
	// slot i holds a read whose data master i has not collected yet
	logic [MASTERCOUNT-1:0] rd_pend;
	logic rdy_en;
	logic q_we, q_take, q_empty, q_full, q_nearfull, next_is_rd;
	pi_req_t q_head, q_next;

	assign wr_lo = wr_idx[MASTERIDXSZ-1:0];
	assign rd_lo = rd_idx[MASTERIDXSZ-1:0];

	// past the last slot of the rotation the index goes back to slot 0
	// and flips the wrap bit
	assign wr_next = (wr_lo == mstrhi) ? {~wr_idx[MASTERIDXSZ], {MASTERIDXSZ{1'b0}}} :
		wr_idx + 1'b1;
	assign rd_next = (rd_lo == slvhi) ? {~rd_idx[MASTERIDXSZ], {MASTERIDXSZ{1'b0}}} :
		rd_idx + 1'b1;

	// usage is the index difference, and when the wrap bits differ the
	// read side still has to finish its own lap up to slvhi first
	assign usage = (wr_idx[MASTERIDXSZ] == rd_idx[MASTERIDXSZ]) ?
		({1'b0, wr_lo} - {1'b0, rd_lo}) :
		({1'b0, slvhi} + 1'b1 - {1'b0, rd_lo} + {1'b0, wr_lo});

	assign q_empty = (usage == '0);
	assign q_full = (usage == {1'b0, mstrhi} + 1'b1);
	// one free slot left, and it is the one read out last
	assign q_nearfull = (usage == {1'b0, mstrhi});

	pi_queue_ram u_queue_ram (
		.m_clk_i  (m_clk_i),
		.we_i     (q_we),
		.waddr_i  (wr_lo),
		.wdata_i  (m_req_i[wr_lo]),
		.raddr0_i (rd_lo),
		.raddr1_i (wr_lo),
		.rdata0_o (q_head),
		.rdata1_o (q_next)
	);

	// a read in that slot may still be waiting for its data from the slave
	assign next_is_rd = (q_next.op == PIRDOP) || (q_next.op == PIRWOP);

	// only the slot under the write index can be ready, and only once both
	// sides of the queue run the same rotation
	always_comb begin
		for (int i = 0; i < MASTERCOUNT; i++) begin
			m_rdy_o[i] = rdy_en && (wr_lo == MASTERIDXSZ'(i)) && (mstrhi == slvhi) &&
				!q_full && (!q_nearfull || !next_is_rd);
		end
	end

	// every ready edge takes the request, a no-op included
	assign q_we = |m_rdy_o;
	assign q_take = s_rdy_i && !q_empty;

	always_comb begin
		s_req_o = q_head;
		if (q_empty) begin
			s_req_o.op = PINOOP;
		end
	end

	// down-counting scan for the highest master that still needs a turn,
	// either to issue something or to collect its read data
	assign scan_hit = (m_req_i[scan_idx].op != PINOOP) || rd_pend[scan_idx];

	always_ff @(posedge m_clk_i) begin
		if (rst_i) begin
			scan_idx <= MASTERIDXSZ'(MASTERCOUNT - 1);
			mstrhinxt <= MASTERIDXSZ'(MASTERCOUNT - 1);
		end else if (scan_hit || scan_idx == '0) begin
			// the rotation never drops below two slots
			if (scan_hit) begin
				mstrhinxt <= (scan_idx != '0) ? scan_idx : MASTERIDXSZ'(1);
			end
			scan_idx <= MASTERIDXSZ'(MASTERCOUNT - 1);
		end else begin
			scan_idx <= scan_idx - 1'b1;
		end
	end

	// write side, the rotation limit only moves at the write wrap
	always_ff @(posedge m_clk_i) begin
		if (rst_i) begin
			wr_idx <= '0;
			mstrhi <= MASTERIDXSZ'(MASTERCOUNT - 1);
			rd_pend <= '0;
			rdy_en <= 1'b0;
		end else begin
			// keeps every ready low for one more cycle after reset
			rdy_en <= 1'b1;
			if (q_we) begin
				wr_idx <= wr_next;
				rd_pend[wr_lo] <= (m_req_i[wr_lo].op == PIRDOP) ||
					(m_req_i[wr_lo].op == PIRWOP);
				if (wr_lo == mstrhi) begin
					mstrhi <= mstrhinxt;
				end
			end
		end
	end

	// read side follows the new rotation at its own wrap
	always_ff @(posedge m_clk_i) begin
		if (rst_i) begin
			rd_idx <= '0;
			slvhi <= MASTERIDXSZ'(MASTERCOUNT - 1);
			prev_rd <= '0;
		end else if (q_take) begin
			prev_rd <= rd_lo;
			rd_idx <= rd_next;
			if (rd_lo == slvhi) begin
				slvhi <= mstrhi;
			end
		end
	end

	// the slave result belongs to the slot accepted before this edge
	always_ff @(posedge m_clk_i) begin
		if (s_rdy_i) begin
			m_data_o[prev_rd] <= s_data_i;
		end
	end

	a_rdy_onehot: assert property (@(posedge m_clk_i) disable iff (rst_i)
		$onehot0(m_rdy_o));

	a_usage_bound: assert property (@(posedge m_clk_i) disable iff (rst_i)
		usage <= MASTERCOUNT);

endmodule

`default_nettype wire

/* hw/pi_pkg.sv */
////////////////////////////////////////
// pi bus definitions
// widths, operation codes and the request
// struct shared by the queue and the slave
////////////////////////////////////////
`default_nettype none

package pi_pkg;

	// one data word, with byte addresses dropped from the word address
	localparam int ARCHBITSZ = 32;
	localparam int ADDRBITSZ = ARCHBITSZ - 2;
	localparam int SELBITSZ = ARCHBITSZ / 8;

	// number of masters sharing the slave, any value of 2 or more works
	localparam int MASTERCOUNT = 3;
	localparam int MASTERIDXSZ = $clog2(MASTERCOUNT);

	// the slave RAM only decodes the low address bits, 64 words
	localparam int RAMADDRSZ = 6;

	typedef logic [1:0] pi_op_t;

	// bus operation codes, a no-op means the master is idle
	localparam pi_op_t PINOOP = 2'd0;
	localparam pi_op_t PIWROP = 2'd1;
	localparam pi_op_t PIRDOP = 2'd2;
	localparam pi_op_t PIRWOP = 2'd3;

	typedef logic [ADDRBITSZ-1:0] pi_addr_t;
	typedef logic [ARCHBITSZ-1:0] pi_data_t;
	typedef logic [SELBITSZ-1:0] pi_sel_t;

	// one memory operation as issued by a master and replayed to the slave
	typedef struct packed {
		pi_op_t op;
		pi_addr_t addr;
		pi_data_t data;
		pi_sel_t sel;
	} pi_req_t;

endpackage

`default_nettype wire

/* hw/pi_queue_ram.sv */
////////////////////////////////////////
// pi queue memory
// one entry per master slot, synchronous
// write and two asynchronous read ports
////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module pi_queue_ram (
	input  wire logic                         m_clk_i,
	input  wire logic                         we_i,
	input  wire logic [pi_pkg::MASTERIDXSZ-1:0] waddr_i,
	input  wire pi_pkg::pi_req_t              wdata_i,
	input  wire logic [pi_pkg::MASTERIDXSZ-1:0] raddr0_i,
	input  wire logic [pi_pkg::MASTERIDXSZ-1:0] raddr1_i,
	output pi_pkg::pi_req_t                   rdata0_o,
	output pi_pkg::pi_req_t                   rdata1_o
);
	import pi_pkg::*;

	// each slot always belongs to the same master
	pi_req_t mem [MASTERCOUNT];

	always_ff @(posedge m_clk_i) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
	end

	// port 0 is the head of the queue toward the slave
	assign rdata0_o = mem[raddr0_i];
	// port 1 shows what the slot about to be written still holds
	assign rdata1_o = mem[raddr1_i];

	// the write index in pi1q skips past the last slot, it never lands beyond it
	a_waddr_in_range: assert property (@(posedge m_clk_i)
		we_i |-> (int'(waddr_i) < MASTERCOUNT));

endmodule

`default_nettype wire

/* hw/pi_ram_slave.sv */
////////////////////////////////////////
// pi RAM slave
// byte-selectable word RAM doing write,
// read and swap, stalls one cycle after
// every write
////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module pi_ram_slave (
	input  wire logic             m_clk_i,
	input  wire logic             rst_i,
	input  wire pi_pkg::pi_req_t  s_req_i,
	output logic                  s_rdy_o,
	output pi_pkg::pi_data_t      s_data_o
);
	import pi_pkg::*;

	pi_data_t mem [2**RAMADDRSZ];
	logic [RAMADDRSZ-1:0] word_addr;
	pi_data_t old_word, new_word;
	logic do_wr, do_rd;
	// set for the one cycle after a write or swap went in
	logic hold_q;

	// the RAM comes up cleared
	initial begin
		for (int i = 0; i < 2**RAMADDRSZ; i++) begin
			mem[i] = '0;
		end
	end

	assign s_rdy_o = !hold_q;

	// upper address bits are not decoded
	assign word_addr = s_req_i.addr[RAMADDRSZ-1:0];
	assign old_word = mem[word_addr];

	// a request is taken whenever the slave is ready
	assign do_wr = s_rdy_o && (s_req_i.op == PIWROP || s_req_i.op == PIRWOP);
	assign do_rd = s_rdy_o && (s_req_i.op == PIRDOP || s_req_i.op == PIRWOP);

	// only the bytes under sel are replaced
	always_comb begin
		new_word = old_word;
		for (int b = 0; b < SELBITSZ; b++) begin
			if (s_req_i.sel[b]) begin
				new_word[8*b +: 8] = s_req_i.data[8*b +: 8];
			end
		end
	end

	// a swap returns the word as it was before the merge
	always_ff @(posedge m_clk_i) begin
		if (do_wr) begin
			mem[word_addr] <= new_word;
		end
		if (do_rd) begin
			s_data_o <= old_word;
		end
	end

	always_ff @(posedge m_clk_i) begin
		if (rst_i) begin
			hold_q <= 1'b0;
		end else begin
			hold_q <= do_wr;
		end
	end

	// the stall after a write lasts exactly one cycle
	a_single_stall: assert property (@(posedge m_clk_i) disable iff (rst_i)
		!s_rdy_o |=> s_rdy_o);

endmodule

`default_nettype wire

/* hw/pi_subsys_top.sv */
////////////////////////////////////////
// pi subsystem top
// masters reach the RAM slave through the
// pi1q queue
////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module pi_subsys_top (
	input  wire logic                      m_clk_i,
	input  wire logic                      rst_i,
	input  wire pi_pkg::pi_req_t           m_req_i [pi_pkg::MASTERCOUNT],
	output logic [pi_pkg::MASTERCOUNT-1:0] m_rdy_o,
	output pi_pkg::pi_data_t               m_data_o [pi_pkg::MASTERCOUNT]
);
	import pi_pkg::*;

	// queue head toward the slave and the slave's answer
	pi_req_t s_req;
	logic s_rdy;
	pi_data_t s_data;

	// all masters share one clock with the slave
	pi1q u_pi1q (
		.m_clk_i  (m_clk_i),
		.rst_i    (rst_i),
		.m_req_i  (m_req_i),
		.m_rdy_o  (m_rdy_o),
		.m_data_o (m_data_o),
		.s_req_o  (s_req),
		.s_rdy_i  (s_rdy),
		.s_data_i (s_data)
	);

	// the slave's stall after a write is what backs up the queue
	pi_ram_slave u_ram_slave (
		.m_clk_i  (m_clk_i),
		.rst_i    (rst_i),
		.s_req_i  (s_req),
		.s_rdy_o  (s_rdy),
		.s_data_o (s_data)
	);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and searches the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_pi_subsys \
	-Mdir obj_dir > build.log 2>&1 \
	&& ./obj_dir/Vtb_pi_subsys > sim.log 2>&1 \
	|| { cat build.log sim.log 2> /dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"

/* sim/pi_checker.sv */
////////////////////////////////////////
// pi subsystem checker
// replays each captured request on a model
// memory and checks the read data that
// every master gets on its next ready
////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module pi_checker (
	input  wire logic                           m_clk_i,
	input  wire logic                           rst_i,
	input  wire pi_pkg::pi_req_t                m_req_i [pi_pkg::MASTERCOUNT],
	input  wire logic [pi_pkg::MASTERCOUNT-1:0] m_rdy_i,
	input  wire pi_pkg::pi_data_t               m_data_i [pi_pkg::MASTERCOUNT],
	input  wire logic [3:0]                     test_i,
	input  wire logic                           done_i,
	output int                                  checks_o,
	output int                                  errors_o
);
	import pi_pkg::*;

	// the ready rule is watched on every cycle and reported as a test of its own
	localparam logic [3:0] RDYTEST = 4'd6;

	pi_data_t model [2**RAMADDRSZ];
	pi_data_t exp_data [MASTERCOUNT];
	logic [3:0] exp_test [MASTERCOUNT];
	logic [MASTERCOUNT-1:0] exp_vld = '0;
	int test_checks [16] = '{default: 0};
	int test_errors [16] = '{default: 0};
	logic [3:0] test_q = '0;
	logic rst_q = 1'b1;
	logic done_q = 1'b0;

	// the slave RAM comes up cleared, so the model does too
	initial begin
		checks_o = 0;
		errors_o = 0;
		foreach (model[a]) begin
			model[a] = '0;
		end
	end

	task automatic count_check(input logic [3:0] t, input logic ok);
		checks_o++;
		test_checks[t]++;
		if (!ok) begin
			errors_o++;
			test_errors[t]++;
		end
	endtask

	task automatic report_test(input logic [3:0] t);
		$display("test %0d done, %0d checks, %0d errors", t, test_checks[t], test_errors[t]);
	endtask

	// capture order at the queue is also the order in which the slave sees requests
	task automatic apply_req(input int m);
		pi_req_t req;
		logic [RAMADDRSZ-1:0] a;
		req = m_req_i[m];
		a = req.addr[RAMADDRSZ-1:0];
		if (req.op == PIRDOP || req.op == PIRWOP) begin
			exp_data[m] = model[a];
			exp_vld[m] = 1'b1;
			exp_test[m] = test_i;
		end
		if (req.op == PIWROP || req.op == PIRWOP) begin
			for (int b = 0; b < SELBITSZ; b++) begin
				if (req.sel[b]) begin
					model[a][8*b +: 8] = req.data[8*b +: 8];
				end
			end
		end
	endtask

	always @(posedge m_clk_i) begin
		logic rdy_ok;
		// a group is finished once the table has moved past it
		if (test_i != test_q && test_q != 4'd0) begin
			report_test(test_q);
		end
		if (done_i && !done_q) begin
			report_test(RDYTEST);
		end
		// no turn in reset or in the cycle after it, later at most one at a time
		rdy_ok = (rst_i || rst_q) ? ((|m_rdy_i) !== 1'b1) : $onehot0(m_rdy_i);
		count_check(RDYTEST, rdy_ok);
		if (!rdy_ok) begin
			$display("error at %0d ns: m_rdy_o is %b against the ready rule", $time, m_rdy_i);
		end
		for (int i = 0; i < MASTERCOUNT; i++) begin
			if (!rst_i && m_rdy_i[i] === 1'b1) begin
				if (exp_vld[i]) begin
					count_check(exp_test[i], m_data_i[i] === exp_data[i]);
					if (m_data_i[i] !== exp_data[i]) begin
						$display("error at %0d ns: master %0d read %h, expected %h",
							$time, i, m_data_i[i], exp_data[i]);
					end
					exp_vld[i] = 1'b0;
				end
				apply_req(i);
			end
		end
		test_q = test_i;
		rst_q = rst_i;
		done_q = done_i;
	end

endmodule

`default_nettype wire

/* sim/tb_pi_subsys.sv */
////////////////////////////////////////
// pi subsystem testbench
// drives a table of master requests through
// the queue into the RAM slave
////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module tb_pi_subsys;
	import pi_pkg::*;

	// one row is one request of one master, tagged with its test number
	typedef struct packed {
		logic [3:0] test;
		logic [MASTERIDXSZ-1:0] master;
		pi_req_t req;
	} row_t;

	logic m_clk;
	logic rst;
	pi_req_t m_req [MASTERCOUNT];
	logic [MASTERCOUNT-1:0] m_rdy;
	pi_data_t m_data [MASTERCOUNT];
	logic [3:0] test_id;
	logic done;
	int checks;
	int errors;
	row_t rows [$];
	integer seed;
	int cycles = 0;
	int limit;

	pi_subsys_top DUT (
		.m_clk_i  (m_clk),
		.rst_i    (rst),
		.m_req_i  (m_req),
		.m_rdy_o  (m_rdy),
		.m_data_o (m_data)
	);

	pi_checker u_checker (
		.m_clk_i  (m_clk),
		.rst_i    (rst),
		.m_req_i  (m_req),
		.m_rdy_i  (m_rdy),
		.m_data_i (m_data),
		.test_i   (test_id),
		.done_i   (done),
		.checks_o (checks),
		.errors_o (errors)
	);

	always #5 m_clk = ~m_clk;

	always @(posedge m_clk) begin
		cycles++;
		if (cycles >= limit) begin
			$display("the run timed out after %0d cycles without finishing the table", cycles);
			$display("Test failed");
			$finish;
		end
	end

	task automatic add_row(input int t, input int m, input pi_op_t op, input int addr,
			input pi_data_t data, input pi_sel_t sel);
		row_t row;
		row.test = 4'(t);
		row.master = MASTERIDXSZ'(m);
		row.req.op = op;
		row.req.addr = pi_addr_t'(addr);
		row.req.data = data;
		row.req.sel = sel;
		rows.push_back(row);
	endtask

	task automatic idle_all();
		for (int m = 0; m < MASTERCOUNT; m++) begin
			m_req[m] = '0;
		end
	endtask

	// the row is captured at the rising edge after a cycle with its ready high
	task automatic apply_row(input row_t row);
		@(negedge m_clk);
		idle_all();
		test_id = row.test;
		m_req[row.master] = row.req;
		while (m_rdy[row.master] !== 1'b1) begin
			@(negedge m_clk);
		end
	endtask

	// a few more turns with no-ops so that nothing is left in flight
	task automatic drain_reads();
		int seen;
		seen = 0;
		while (seen < 2 * MASTERCOUNT) begin
			@(negedge m_clk);
			idle_all();
			test_id = '0;
			if (|m_rdy) begin
				seen++;
			end
		end
		@(negedge m_clk);
	endtask

	// columns are test, master, op, word address, data and byte select
	task automatic fill_table();
		add_row(1, 0, PIWROP, 5, 32'hcafe_0123, 4'hf);
		add_row(1, 0, PIRDOP, 5, '0, '0);
		add_row(1, 0, PINOOP, 0, '0, '0);
		// the read after three writes shows the byte merge
		add_row(2, 1, PIWROP, 9, 32'h1122_3344, 4'hf);
		add_row(2, 1, PIWROP, 9, 32'haabb_ccdd, 4'b0101);
		add_row(2, 1, PIWROP, 9, 32'h5566_7788, 4'b1000);
		add_row(2, 1, PIRDOP, 9, '0, '0);
		add_row(2, 1, PINOOP, 0, '0, '0);
		add_row(3, 0, PIWROP, 20, 32'h0bad_f00d, 4'hf);
		add_row(3, 0, PIRWOP, 20, 32'h1234_5678, 4'hf);
		add_row(3, 0, PIRDOP, 20, '0, '0);
		add_row(3, 0, PINOOP, 0, '0, '0);
		// three masters on one address, the last master two is followed by its own no-op
		add_row(4, 0, PIWROP, 33, 32'h1111_1111, 4'hf);
		add_row(4, 1, PIRDOP, 33, '0, '0);
		add_row(4, 2, PIWROP, 33, 32'h2222_2222, 4'b0011);
		add_row(4, 0, PIRDOP, 33, '0, '0);
		add_row(4, 1, PIRWOP, 33, 32'h3333_3333, 4'b1100);
		add_row(4, 2, PIRDOP, 33, '0, '0);
		add_row(4, 2, PINOOP, 0, '0, '0);
		add_row(4, 0, PINOOP, 0, '0, '0);
		add_row(4, 1, PINOOP, 0, '0, '0);
		// back-to-back writes keep the slave stalling every other cycle
		add_row(5, 0, PIWROP, 40, $random(seed), 4'hf);
		add_row(5, 1, PIWROP, 41, $random(seed), 4'hf);
		add_row(5, 2, PIWROP, 42, $random(seed), 4'hf);
		add_row(5, 0, PIWROP, 40, $random(seed), 4'b0110);
		add_row(5, 1, PIRDOP, 40, '0, '0);
		add_row(5, 0, PIRDOP, 41, '0, '0);
		add_row(5, 2, PIRDOP, 42, '0, '0);
		add_row(5, 2, PINOOP, 0, '0, '0);
		add_row(5, 1, PINOOP, 0, '0, '0);
		add_row(5, 0, PINOOP, 0, '0, '0);
	endtask

	initial begin
		m_clk = 1'b0;
		rst = 1'b1;
		done = 1'b0;
		test_id = '0;
		seed = 32'hd2269211;
		idle_all();
		fill_table();
		// a few rotation laps per row, with room for reset and the drain
		limit = rows.size() * MASTERCOUNT * 4 + 200;
		repeat (10) @(posedge m_clk);
		@(negedge m_clk);
		rst = 1'b0;
		foreach (rows[r]) begin
			apply_row(rows[r]);
		end
		drain_reads();
		done = 1'b1;
		repeat (2) @(negedge m_clk);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
hw/pi_pkg.sv
hw/pi_queue_ram.sv
hw/pi1q.sv
hw/pi_ram_slave.sv
hw/pi_subsys_top.sv
sim/pi_checker.sv
sim/tb_pi_subsys.sv
